// ==== hw/plateau_pkg.sv ====
/*
 * Plateau detector shared definitions
 * Stream widths, window and delay lengths, settings address and tracker states
 */
package plateau_pkg;

  localparam int METRIC_W     = 16;
  // I in the upper half, Q in the lower half
  localparam int SAMPLE_W     = 32;
  localparam int AVG_LEN      = 8;
  localparam int AVG_SHIFT    = 3;
  localparam int SAMPLE_DELAY = 128;
  localparam int PREAMBLE_LEN = 48;
  // Preamble start sits this many items ahead of the first averaged peak
  localparam int PLATEAU_LAG  = 16;
  localparam int OFFSET_W     = 8;

  localparam logic [7:0]  SR_THRESHOLD      = 8'd5;
  localparam logic [15:0] DEFAULT_THRESHOLD = 16'd1000;

  typedef logic [METRIC_W-1:0] metric_t;
  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  typedef enum logic [2:0] {
    S_WAIT_EXCEED,
    S_FIND_FIRST,
    S_WAIT_EXCEED2,
    S_FIND_SECOND,
    S_ALIGN,
    S_WAIT_BELOW
  } tracker_state_t;

endpackage

// ==== hw/metric_averager.sv ====
/*
 * Metric averager
 * Moving average of the D metric over the plateau window, sample carried alongside
 */
`timescale 1ns/1ps

module metric_averager import plateau_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  sample_t i_sample,
  input  metric_t i_metric,
  input  logic    i_valid,
  output logic    o_ready,
  output sample_t o_sample,
  output metric_t o_metric,
  output logic    o_valid,
  input  logic    i_ready
);

  metric_t                       hist [AVG_LEN];
  logic [AVG_SHIFT-1:0]          hist_ptr;
  logic [METRIC_W+AVG_SHIFT-1:0] run_sum;
  logic [METRIC_W+AVG_SHIFT-1:0] sum_next;
  logic                          accept;

  // Output register empty or being drained this cycle
  assign o_ready = !o_valid || i_ready;
  assign accept  = i_valid && o_ready;

  // Newest value in, oldest value out
  always_comb begin
    sum_next = run_sum + {{AVG_SHIFT{1'b0}}, i_metric} - {{AVG_SHIFT{1'b0}}, hist[hist_ptr]};
  end

  // History starts at zero so early averages count missing terms as zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < AVG_LEN; i++) begin
        hist[i] <= '0;
      end
      hist_ptr <= '0;
      run_sum  <= '0;
    end else if (accept) begin
      hist[hist_ptr] <= i_metric;
      hist_ptr       <= hist_ptr + 1'b1;
      run_sum        <= sum_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid <= 1'b0;
    end else if (accept) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  // Divide by the window length
  always_ff @(posedge clk) begin
    if (accept) begin
      o_sample <= i_sample;
      o_metric <= sum_next[METRIC_W+AVG_SHIFT-1:AVG_SHIFT];
    end
  end

  // Upstream holds its item until it is taken
  a_input_stable : assert property (
    @(posedge clk) disable iff (reset)
    i_valid && !o_ready |=> i_valid && $stable(i_sample) && $stable(i_metric)
  ) else $error("Input changed while stalled");

endmodule

// ==== hw/sample_delay_line.sv ====
/*
 * Sample delay line
 * Delays samples by a fixed item count and pairs them with the current average
 */
`timescale 1ns/1ps

module sample_delay_line import plateau_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  sample_t i_sample,
  input  metric_t i_metric,
  input  logic    i_valid,
  output logic    o_ready,
  output sample_t o_sample,
  output metric_t o_metric,
  output logic    o_valid,
  input  logic    i_ready
);

  sample_t                         ram [SAMPLE_DELAY];
  logic [$clog2(SAMPLE_DELAY)-1:0] wr_ptr;
  logic [$clog2(SAMPLE_DELAY):0]   fill_cnt;
  logic                            filled;
  logic                            accept;

  assign o_ready = !o_valid || i_ready;
  assign accept  = i_valid && o_ready;
  assign filled  = (fill_cnt == SAMPLE_DELAY);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
    end else if (accept) begin
      if (wr_ptr == SAMPLE_DELAY - 1) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Saturates once the RAM holds a full delay of samples
      if (!filled) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  // Read-before-write on the same address gives the item from SAMPLE_DELAY ago
  always_ff @(posedge clk) begin
    if (accept) begin
      ram[wr_ptr] <= i_sample;
      o_sample    <= filled ? ram[wr_ptr] : '0;
      o_metric    <= i_metric;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid <= 1'b0;
    end else if (accept) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  // Until the first wrap the write pointer follows the fill count
  a_ptr_in_step : assert property (
    @(posedge clk) disable iff (reset)
    !filled |-> wr_ptr == fill_cnt[$clog2(SAMPLE_DELAY)-1:0]
  ) else $error("Delay line pointer out of step with fill count");

endmodule

// ==== hw/preamble_peak_tracker.sv ====
/*
 * Preamble peak tracker
 * Two-plateau peak search on the averaged metric, marks the item before the preamble
 */
`timescale 1ns/1ps

module preamble_peak_tracker import plateau_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  sample_t     i_sample,
  input  metric_t     i_metric,
  input  logic        i_valid,
  output logic        o_ready,
  output sample_t     o_sample,
  output logic        o_last,
  output logic        o_valid,
  input  logic        i_ready
);

  metric_t        threshold;
  tracker_state_t state;
  metric_t        max_metric;
  metric_t        max_87_5;
  offset_t        peak_offset;
  offset_t        align_cnt;
  logic           accept;
  logic           exceeded;
  logic           dropped;
  logic           last_hit;
  logic           last_sent;

  assign o_ready = !o_valid || i_ready;
  assign accept  = i_valid && o_ready;

  assign max_87_5 = max_metric - (max_metric >> 3);
  assign exceeded = i_metric > threshold;
  assign dropped  = i_metric < max_87_5;
  assign last_hit = (state == S_ALIGN) && (align_cnt == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      threshold <= DEFAULT_THRESHOLD;
    end else if (i_set_stb && i_set_addr == SR_THRESHOLD) begin
      threshold <= i_set_data[METRIC_W-1:0];
    end
  end

  // peak_offset holds the item distance from the first peak to the current item
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= S_WAIT_EXCEED;
      max_metric  <= '0;
      peak_offset <= '0;
      align_cnt   <= '0;
    end else if (accept) begin
      case (state)
        S_WAIT_EXCEED: begin
          peak_offset <= '0;
          if (exceeded) begin
            max_metric  <= i_metric;
            peak_offset <= offset_t'(1);
            state       <= S_FIND_FIRST;
          end
        end

        S_FIND_FIRST: begin
          if (i_metric > max_metric) begin
            max_metric  <= i_metric;
            peak_offset <= offset_t'(1);
          end else begin
            peak_offset <= peak_offset + 1'b1;
            if (dropped) begin
              state <= S_WAIT_EXCEED2;
            end else if (peak_offset > PREAMBLE_LEN / 2) begin
              // Flat for too long, a tone rather than a preamble
              state <= S_WAIT_BELOW;
            end
          end
        end

        S_WAIT_EXCEED2: begin
          peak_offset <= peak_offset + 1'b1;
          if (peak_offset > PREAMBLE_LEN) begin
            state <= S_WAIT_BELOW;
          end else if (exceeded) begin
            max_metric <= i_metric;
            state      <= S_FIND_SECOND;
          end
        end

        S_FIND_SECOND: begin
          peak_offset <= peak_offset + 1'b1;
          if (i_metric > max_metric) begin
            max_metric <= i_metric;
          end
          if (peak_offset > 2 * PREAMBLE_LEN) begin
            state <= S_WAIT_BELOW;
          end else if (dropped) begin
            // Items left until first peak + SAMPLE_DELAY - PLATEAU_LAG - 1
            align_cnt <= offset_t'(SAMPLE_DELAY - PLATEAU_LAG - 2) - peak_offset;
            state     <= S_ALIGN;
          end
        end

        S_ALIGN: begin
          if (last_hit) begin
            state <= S_WAIT_BELOW;
          end else begin
            align_cnt <= align_cnt - 1'b1;
          end
        end

        S_WAIT_BELOW: begin
          if (!exceeded) begin
            state <= S_WAIT_EXCEED;
          end
        end

        default: state <= S_WAIT_EXCEED;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end else if (accept) begin
      o_valid <= 1'b1;
      o_last  <= last_hit;
    end else if (i_ready) begin
      o_valid <= 1'b0;
      o_last  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_sample <= i_sample;
    end
  end

  // Remembers whether the previous output transfer carried o_last
  always_ff @(posedge clk) begin
    if (reset) begin
      last_sent <= 1'b0;
    end else if (o_valid && i_ready) begin
      last_sent <= o_last;
    end
  end

  // The marked item leaves only after the search has moved on
  a_last_valid : assert property (
    @(posedge clk) disable iff (reset)
    o_last |-> o_valid && state == S_WAIT_BELOW
  ) else $error("o_last without o_valid or outside S_WAIT_BELOW");

  a_last_single : assert property (
    @(posedge clk) disable iff (reset)
    o_valid && i_ready |-> !(o_last && last_sent)
  ) else $error("o_last on two consecutive transfers");

endmodule

// ==== hw/plateau_detector_top.sv ====
/*
 * OFDM preamble plateau detector
 * Averager, sample delay line and peak tracker in series
 */
`timescale 1ns/1ps

module plateau_detector_top import plateau_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        i_set_stb,
  input  logic [7:0]  i_set_addr,
  input  logic [31:0] i_set_data,
  input  sample_t     i_sample,
  input  metric_t     i_metric,
  input  logic        i_valid,
  output logic        o_ready,
  output sample_t     o_sample,
  output logic        o_last,
  output logic        o_valid,
  input  logic        i_ready
);

  sample_t avg_sample;
  metric_t avg_metric;
  logic    avg_valid;
  logic    avg_ready;
  sample_t dly_sample;
  metric_t dly_metric;
  logic    dly_valid;
  logic    dly_ready;

  metric_averager metric_averager_i (
    .clk(clk), .reset(reset),
    .i_sample(i_sample), .i_metric(i_metric), .i_valid(i_valid), .o_ready(o_ready),
    .o_sample(avg_sample), .o_metric(avg_metric), .o_valid(avg_valid), .i_ready(avg_ready)
  );

  sample_delay_line sample_delay_line_i (
    .clk(clk), .reset(reset),
    .i_sample(avg_sample), .i_metric(avg_metric), .i_valid(avg_valid), .o_ready(avg_ready),
    .o_sample(dly_sample), .o_metric(dly_metric), .o_valid(dly_valid), .i_ready(dly_ready)
  );

  preamble_peak_tracker preamble_peak_tracker_i (
    .clk(clk), .reset(reset),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_sample(dly_sample), .i_metric(dly_metric), .i_valid(dly_valid), .o_ready(dly_ready),
    .o_sample(o_sample), .o_last(o_last), .o_valid(o_valid), .i_ready(i_ready)
  );

endmodule

// ==== verif/plateau_detector_tb.sv ====
/*
 * Plateau detector testbench
 * Directed tests of detection, timeouts, back-pressure and the threshold register
 */
`timescale 1ns/1ps

module plateau_detector_tb import plateau_pkg::*; ();

  localparam int MAX_ITEMS = 400;
  localparam int TIMEOUT = 2000;
  // Plateau level sits just above the default threshold
  localparam metric_t LEVEL = 16'd1120;

  logic        clk = 1'b0;
  logic        reset;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  sample_t     i_sample;
  metric_t     i_metric;
  logic        i_valid;
  logic        o_ready;
  sample_t     o_sample;
  logic        o_last;
  logic        o_valid;
  logic        i_ready;

  logic [31:0] lcg_state = 32'h2438;
  metric_t     met [MAX_ITEMS];
  sample_t     smp [MAX_ITEMS];
  logic        exp_last [MAX_ITEMS];
  sample_t     got_sample [MAX_ITEMS];
  logic        got_last [MAX_ITEMS];
  int          got_cnt;
  logic        bp_mode;
  logic        timed_out;
  string       cur_test;
  int          errors;
  int          err_mark;
  int          tests_passed;
  int          tests_failed;

  plateau_detector_top plateau_detector_top_i (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Output side ready, random under back-pressure
  always @(posedge clk) begin
    #0.5;
    if (bp_mode) begin
      i_ready = lcg_next() > 32'h6000_0000;
    end else begin
      i_ready = 1'b1;
    end
  end

  // Record each output transfer mid-cycle, where everything is stable
  always @(negedge clk) begin
    if (!reset && o_valid && i_ready && got_cnt < MAX_ITEMS) begin
      got_sample[got_cnt] = o_sample;
      got_last[got_cnt]   = o_last;
      got_cnt++;
    end
  end

  initial begin
    wait (timed_out);
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed + 1);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic report_timeout(input string why);
    $display("ERROR %s: %s", cur_test, why);
    timed_out = 1'b1;
  endtask

  task automatic check_sample(input int idx, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s sample %0d: expected %h, actual %h", cur_test, idx, exp, act);
    end
  endtask

  task automatic check_last(input int idx, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s o_last at item %0d: expected %b, actual %b", cur_test, idx, exp, act);
    end
  endtask

  task automatic check_count(input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("FAIL %s o_last pulses: expected %0d, actual %0d", cur_test, exp, act);
    end
  endtask

  task automatic apply_reset();
    reset   = 1'b1;
    i_valid = 1'b0;
    repeat (8) @(posedge clk);
    #0.5;
    reset   = 1'b0;
    got_cnt = 0;
  endtask

  task automatic write_threshold(input metric_t thr);
    i_set_stb  = 1'b1;
    i_set_addr = SR_THRESHOLD;
    i_set_data = 32'(thr);
    @(posedge clk);
    #0.5;
    i_set_stb  = 1'b0;
  endtask

  // Low noise metric and random samples
  task automatic build_noise(input int n);
    for (int k = 0; k < n; k++) begin
      met[k] = metric_t'(lcg_next() % 64);
      smp[k] = sample_t'(lcg_next());
    end
  endtask

  task automatic add_plateau(input int start, input int len);
    for (int k = start; k < start + len; k++) begin
      met[k] = LEVEL;
    end
  endtask

  // Two plateaus of 16 items, second one 32 items after the first
  task automatic add_preamble(input int start);
    add_plateau(start, 16);
    add_plateau(start + 32, 16);
  endtask

  // Expected o_last per item from the moving average and the search rules
  task automatic model_last(input int n, input metric_t thr);
    tracker_state_t st;
    int unsigned    sum;
    metric_t        avg;
    metric_t        mx;
    int             p;
    st = S_WAIT_EXCEED;
    mx = '0;
    p  = 0;
    for (int k = 0; k < n; k++) begin
      sum = 0;
      for (int j = 0; j < AVG_LEN; j++) begin
        if (k - j >= 0) begin
          sum = sum + 32'(met[k - j]);
        end
      end
      avg = metric_t'(sum >> AVG_SHIFT);
      exp_last[k] = 1'b0;
      case (st)
        S_WAIT_EXCEED: begin
          if (avg > thr) begin
            mx = avg;
            p  = k;
            st = S_FIND_FIRST;
          end
        end
        S_FIND_FIRST: begin
          if (avg > mx) begin
            mx = avg;
            p  = k;
          end else if (8 * int'(avg) < 7 * int'(mx)) begin
            // Below 87.5 % of the peak
            st = S_WAIT_EXCEED2;
          end else if (k - p > PREAMBLE_LEN / 2) begin
            st = S_WAIT_BELOW;
          end
        end
        S_WAIT_EXCEED2: begin
          if (k - p > PREAMBLE_LEN) begin
            st = S_WAIT_BELOW;
          end else if (avg > thr) begin
            mx = avg;
            st = S_FIND_SECOND;
          end
        end
        S_FIND_SECOND: begin
          if (k - p > 2 * PREAMBLE_LEN) begin
            st = S_WAIT_BELOW;
          end else if (8 * int'(avg) < 7 * int'(mx)) begin
            st = S_ALIGN;
          end
          if (avg > mx) begin
            mx = avg;
          end
        end
        S_ALIGN: begin
          if (k == p + SAMPLE_DELAY - PLATEAU_LAG - 1) begin
            exp_last[k] = 1'b1;
            st = S_WAIT_BELOW;
          end
        end
        default: begin
          if (avg <= thr) begin
            st = S_WAIT_EXCEED;
          end
        end
      endcase
    end
  endtask

  task automatic drive_items(input int n);
    int   cyc;
    logic took;
    for (int k = 0; k < n; k++) begin
      // Occasional idle cycle under back-pressure
      if (bp_mode && lcg_next() < 32'h4000_0000) begin
        i_valid = 1'b0;
        @(posedge clk);
        #0.5;
      end
      i_sample = smp[k];
      i_metric = met[k];
      i_valid  = 1'b1;
      cyc  = 0;
      took = 1'b0;
      while (!took && cyc <= TIMEOUT) begin
        @(negedge clk);
        took = o_ready;
        @(posedge clk);
        #0.5;
        cyc++;
      end
      if (!took) begin
        report_timeout("input item was never accepted");
      end
    end
    i_valid = 1'b0;
  endtask

  task automatic wait_outputs(input int n);
    int cyc;
    cyc = 0;
    while (got_cnt < n && cyc <= TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    if (got_cnt < n) begin
      report_timeout("not all output items arrived");
    end
    repeat (4) @(posedge clk);
    #0.5;
  endtask

  task automatic run_stream(input int n, input metric_t thr, input logic bp, input int pulses);
    int count;
    apply_reset();
    if (thr != DEFAULT_THRESHOLD) begin
      write_threshold(thr);
    end
    model_last(n, thr);
    bp_mode = bp;
    drive_items(n);
    wait_outputs(n);
    bp_mode = 1'b0;
    if (got_cnt != n) begin
      errors++;
      $display("FAIL %s output items: expected %0d, actual %0d", cur_test, n, got_cnt);
    end
    count = 0;
    for (int k = 0; k < n; k++) begin
      check_sample(k, (k >= SAMPLE_DELAY) ? smp[k - SAMPLE_DELAY] : '0, got_sample[k]);
      check_last(k, exp_last[k], got_last[k]);
      if (got_last[k]) begin
        count++;
      end
    end
    check_count(pulses, count);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      tests_passed++;
      $display("Test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", cur_test, errors - err_mark);
    end
  endtask

  initial begin
    reset        = 1'b1;
    i_set_stb    = 1'b0;
    i_set_addr   = '0;
    i_set_data   = '0;
    i_sample     = '0;
    i_metric     = '0;
    i_valid      = 1'b0;
    i_ready      = 1'b1;
    bp_mode      = 1'b0;
    timed_out    = 1'b0;
    got_cnt      = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;

    start_test("idle_after_reset");
    apply_reset();
    for (int k = 0; k < 10; k++) begin
      @(negedge clk);
      if (o_valid) begin
        errors++;
        $display("ERROR %s: o_valid went high with no input", cur_test);
      end
    end
    build_noise(300);
    run_stream(300, DEFAULT_THRESHOLD, 1'b0, 0);
    end_test();

    start_test("single_preamble");
    build_noise(260);
    add_preamble(40);
    run_stream(260, DEFAULT_THRESHOLD, 1'b0, 1);
    end_test();

    // Same stream as the previous test
    start_test("back_pressure");
    run_stream(260, DEFAULT_THRESHOLD, 1'b1, 1);
    end_test();

    start_test("first_plateau_only");
    build_noise(260);
    add_plateau(40, 16);
    run_stream(260, DEFAULT_THRESHOLD, 1'b0, 0);
    end_test();

    start_test("threshold_register");
    build_noise(260);
    add_preamble(40);
    run_stream(260, 16'd1500, 1'b0, 0);
    run_stream(260, 16'd900, 1'b0, 1);
    end_test();

    start_test("tone_rejection");
    build_noise(320);
    add_plateau(20, 100);
    add_preamble(150);
    run_stream(320, DEFAULT_THRESHOLD, 1'b0, 1);
    end_test();

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hw/plateau_pkg.sv
hw/metric_averager.sv
hw/sample_delay_line.sv
hw/preamble_peak_tracker.sv
hw/plateau_detector_top.sv
verif/plateau_detector_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the plateau detector testbench with Verilator
verilator --binary --timing --assert --top-module plateau_detector_tb -f sources.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run error"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0
